// File: design/tcdm_fifo.sv
// TCDM decoupling queue top
`timescale 1ns/1ps
`default_nettype none

module tcdm_fifo (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  logic                    clear_i,

  // core side request
  input  logic                    tgt_req_i,
  input  tcdm_fifo_pkg::addr_t    tgt_addr_i,
  input  tcdm_fifo_pkg::data_t    tgt_wdata_i,
  input  tcdm_fifo_pkg::be_t      tgt_be_i,
  input  tcdm_fifo_pkg::tcdm_op_e tgt_op_i,
  output logic                    tgt_gnt_o,

  // core side response
  output logic                    tgt_r_valid_o,
  output tcdm_fifo_pkg::data_t    tgt_r_data_o,
  input  logic                    tgt_r_ready_i,

  // memory side request
  output logic                    init_req_o,
  output tcdm_fifo_pkg::addr_t    init_addr_o,
  output tcdm_fifo_pkg::data_t    init_wdata_o,
  output tcdm_fifo_pkg::be_t      init_be_o,
  output tcdm_fifo_pkg::tcdm_op_e init_op_o,
  input  logic                    init_gnt_i,

  // memory side response
  input  logic                    init_r_valid_i,
  input  tcdm_fifo_pkg::data_t    init_r_data_i,
  output logic                    init_r_ready_o,

  output logic                    empty_o          // both queues drained
);

  import tcdm_fifo_pkg::*;

  req_word_t req_push_word;   // packed core request
  req_word_t req_pop_word;    // head of the request queue
  logic      req_pop_valid;
  logic      req_pop;
  logic      req_empty;

  logic      rsp_push_valid;
  data_t     rsp_push_data;
  logic      rsp_push_ready;
  logic      rsp_almost_full;
  logic      rsp_empty;

  // pack core side fields, address on top
  assign req_push_word.addr  = tgt_addr_i;
  assign req_push_word.wdata = tgt_wdata_i;
  assign req_push_word.be    = tgt_be_i;
  assign req_push_word.op    = tgt_op_i;

  // unpack queue head onto the memory side
  assign init_addr_o  = req_pop_word.addr;
  assign init_wdata_o = req_pop_word.wdata;
  assign init_be_o    = req_pop_word.be;
  assign init_op_o    = req_pop_word.op;

  // outgoing queue, gnt is simply not-full
  tcdm_sync_fifo #(
    .WIDTH ( REQ_W      ),
    .DEPTH ( FIFO_DEPTH )
  ) i_req_fifo (
    .clk_i         ( clk_i         ),
    .rst_ni        ( rst_ni        ),
    .clear_i       ( clear_i       ),
    .push_valid_i  ( tgt_req_i     ),
    .push_data_i   ( req_push_word ),
    .push_ready_o  ( tgt_gnt_o     ),
    .pop_valid_o   ( req_pop_valid ),
    .pop_data_o    ( req_pop_word  ),
    .pop_ready_i   ( req_pop       ),
    .empty_o       ( req_empty     ),
    .almost_full_o (               )  // gating only watches the response side
  );

  // incoming queue, pop side is the core response port
  tcdm_sync_fifo #(
    .WIDTH ( DATA_W     ),
    .DEPTH ( FIFO_DEPTH )
  ) i_rsp_fifo (
    .clk_i         ( clk_i           ),
    .rst_ni        ( rst_ni          ),
    .clear_i       ( clear_i         ),
    .push_valid_i  ( rsp_push_valid  ),
    .push_data_i   ( rsp_push_data   ),
    .push_ready_o  ( rsp_push_ready  ),
    .pop_valid_o   ( tgt_r_valid_o   ),
    .pop_data_o    ( tgt_r_data_o    ),
    .pop_ready_i   ( tgt_r_ready_i   ),
    .empty_o       ( rsp_empty       ),
    .almost_full_o ( rsp_almost_full )
  );

  // hold register, gating and flags
  tcdm_fifo_ctrl i_ctrl (
    .clk_i             ( clk_i           ),
    .rst_ni            ( rst_ni          ),
    .clear_i           ( clear_i         ),
    .req_valid_i       ( req_pop_valid   ),
    .req_pop_o         ( req_pop         ),
    .init_req_o        ( init_req_o      ),
    .init_gnt_i        ( init_gnt_i      ),
    .init_r_valid_i    ( init_r_valid_i  ),
    .init_r_data_i     ( init_r_data_i   ),
    .init_r_ready_o    ( init_r_ready_o  ),
    .rsp_push_valid_o  ( rsp_push_valid  ),
    .rsp_push_data_o   ( rsp_push_data   ),
    .rsp_push_ready_i  ( rsp_push_ready  ),
    .rsp_almost_full_i ( rsp_almost_full ),
    .tgt_r_ready_i     ( tgt_r_ready_i   ),
    .req_empty_i       ( req_empty       ),
    .rsp_empty_i       ( rsp_empty       ),
    .empty_o           ( empty_o         )
  );

endmodule : tcdm_fifo

`default_nettype wire

// File: design/tcdm_fifo_ctrl.sv
// TCDM queue handshake control
`timescale 1ns/1ps
`default_nettype none

module tcdm_fifo_ctrl (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  logic                 clear_i,

  // request FIFO pop side
  input  logic                 req_valid_i,      // request queued
  output logic                 req_pop_o,

  // memory side handshake
  output logic                 init_req_o,
  input  logic                 init_gnt_i,
  input  logic                 init_r_valid_i,
  input  tcdm_fifo_pkg::data_t init_r_data_i,
  output logic                 init_r_ready_o,

  // response FIFO push side
  output logic                 rsp_push_valid_o,
  output tcdm_fifo_pkg::data_t rsp_push_data_o,
  input  logic                 rsp_push_ready_i,  // not full
  input  logic                 rsp_almost_full_i,

  // core side response ready, seen by the gating
  input  logic                 tgt_r_ready_i,

  // status
  input  logic                 req_empty_i,
  input  logic                 rsp_empty_i,
  output logic                 empty_o
);

  import tcdm_fifo_pkg::*;

  logic  hold_valid_q;     // a response is parked in the hold register
  data_t hold_data_q;      // parked response word, no reset

  logic  live_accept;      // arriving response goes straight in
  logic  held_accept;      // parked response drains this cycle
  logic  rsp_overflow_risk;

  // live response wins over the parked one
  assign rsp_push_valid_o = init_r_valid_i | hold_valid_q;
  assign rsp_push_data_o  = init_r_valid_i ? init_r_data_i : hold_data_q;

  assign live_accept = init_r_valid_i & rsp_push_ready_i;
  assign held_accept = ~init_r_valid_i & hold_valid_q & rsp_push_ready_i;

  // hold valid bit
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      hold_valid_q <= 1'b0;
    end else if (clear_i) begin
      hold_valid_q <= 1'b0;
    end else if (live_accept) begin
      hold_valid_q <= 1'b0;             // response went into the FIFO
    end else if (init_r_valid_i) begin
      hold_valid_q <= 1'b1;             // FIFO full, park it
    end else if (held_accept) begin
      hold_valid_q <= 1'b0;             // parked word released
    end
  end

  // every arriving response is captured, used only when the FIFO refuses it
  always_ff @(posedge clk_i) begin
    if (init_r_valid_i) begin
      hold_data_q <= init_r_data_i;
    end
  end

  // one more response than there is room for could land next cycle:
  // one slot left, one arriving now, and the core is not draining
  assign rsp_overflow_risk = rsp_almost_full_i & init_r_valid_i & ~tgt_r_ready_i;

  // memory request only while the response path has room
  assign init_req_o = req_valid_i & rsp_push_ready_i & ~rsp_overflow_risk;

  // advisory to the memory, the hold register covers a miss
  assign init_r_ready_o = rsp_push_ready_i;

  // pop the request queue on a completed req/gnt transfer
  assign req_pop_o = init_req_o & init_gnt_i;

  // whole queue idle
  assign empty_o = req_empty_i & rsp_empty_i;

endmodule : tcdm_fifo_ctrl

`default_nettype wire

// File: design/tcdm_fifo_pkg.sv
// TCDM decoupling queue definitions
`default_nettype none

package tcdm_fifo_pkg;

  // bus geometry
  localparam int unsigned ADDR_W     = 32;          // byte address
  localparam int unsigned DATA_W     = 32;          // one word per beat
  localparam int unsigned BE_W       = DATA_W / 8;  // one enable per byte
  localparam int unsigned FIFO_DEPTH = 8;           // entries in each direction

  // address + wdata + be + op
  localparam int unsigned REQ_W = ADDR_W + DATA_W + BE_W + 1;

  typedef logic [ADDR_W-1:0] addr_t;
  typedef logic [DATA_W-1:0] data_t;
  typedef logic [BE_W-1:0]   be_t;

  // memory operation, carried on the wire as the write-enable bit
  // read is high, as on the TCDM wen line
  typedef enum logic {
    OP_STORE = 1'b0,
    OP_LOAD  = 1'b1
  } tcdm_op_e;

  // one queued request, address in the top bits
  typedef struct packed {
    addr_t    addr;   // [68:37]
    data_t    wdata;  // [36:5]
    be_t      be;     // [4:1]
    tcdm_op_e op;     // [0]
  } req_word_t;

endpackage : tcdm_fifo_pkg

`default_nettype wire

// File: design/tcdm_sync_fifo.sv
// Registered synchronous FIFO
`timescale 1ns/1ps
`default_nettype none

module tcdm_sync_fifo #(
  parameter int unsigned WIDTH = 32,
  parameter int unsigned DEPTH = 8
) (
  input  logic             clk_i,
  input  logic             rst_ni,
  input  logic             clear_i,        // sync flush, storage untouched

  input  logic             push_valid_i,
  input  logic [WIDTH-1:0] push_data_i,
  output logic             push_ready_o,   // not full

  output logic             pop_valid_o,    // not empty
  output logic [WIDTH-1:0] pop_data_o,
  input  logic             pop_ready_i,

  output logic             empty_o,
  output logic             almost_full_o   // exactly DEPTH-1 entries
);

  localparam int unsigned PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int unsigned CNT_W = $clog2(DEPTH + 1);

  logic [WIDTH-1:0] mem_q [DEPTH];   // word storage, no reset

  logic [PTR_W-1:0] wr_ptr_q, wr_ptr_d;
  logic [PTR_W-1:0] rd_ptr_q, rd_ptr_d;
  logic [CNT_W-1:0] count_q, count_d;

  logic push_fire;
  logic pop_fire;

  // handshakes
  assign push_ready_o = (count_q != CNT_W'(DEPTH));
  assign pop_valid_o  = (count_q != '0);
  assign push_fire    = push_valid_i & push_ready_o;
  assign pop_fire     = pop_valid_o & pop_ready_i;

  // status flags for the gating logic
  assign empty_o       = (count_q == '0);
  assign almost_full_o = (count_q == CNT_W'(DEPTH - 1));

  // head of queue, registered storage so no fall-through
  assign pop_data_o = mem_q[rd_ptr_q];

  // next pointers wrap explicitly, DEPTH need not be a power of two
  always_comb begin
    wr_ptr_d = wr_ptr_q;
    rd_ptr_d = rd_ptr_q;
    count_d  = count_q;
    if (push_fire) begin
      if (wr_ptr_q == PTR_W'(DEPTH - 1)) wr_ptr_d = '0;
      else                                wr_ptr_d = wr_ptr_q + 1'b1;
    end
    if (pop_fire) begin
      if (rd_ptr_q == PTR_W'(DEPTH - 1)) rd_ptr_d = '0;
      else                                rd_ptr_d = rd_ptr_q + 1'b1;
    end
    case ({push_fire, pop_fire})
      2'b10:   count_d = count_q + 1'b1;  // fill
      2'b01:   count_d = count_q - 1'b1;  // drain
      default: count_d = count_q;         // idle or both at once
    endcase
  end

  // pointer and occupancy state
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else if (clear_i) begin
      // flush only drops the bookkeeping
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      wr_ptr_q <= wr_ptr_d;
      rd_ptr_q <= rd_ptr_d;
      count_q  <= count_d;
    end
  end

  // storage write
  always_ff @(posedge clk_i) begin
    if (push_fire) begin
      mem_q[wr_ptr_q] <= push_data_i;  // visible on pop side next cycle
    end
  end

endmodule : tcdm_sync_fifo

`default_nettype wire

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the TCDM queue testbench with Verilator

cd "$(dirname "$0")" || exit 1

top=tb_tcdm_fifo
build_dir=build
log=sim.log

verilator --binary -Wno-fatal --top-module "$top" -f sim.f --Mdir "$build_dir" -o "$top"
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

"./$build_dir/$top" > "$log" 2>&1
status=$?
cat "$log"

if grep -q "TESTS FAILED" "$log"; then
  echo "simulation reported failure, see $log"
  exit 1
fi

if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if ! grep -q "TESTS PASSED" "$log"; then
  echo "no pass line found in $log"
  exit 1
fi

exit 0

// File: sim.f
design/tcdm_fifo_pkg.sv
design/tcdm_sync_fifo.sv
design/tcdm_fifo_ctrl.sv
design/tcdm_fifo.sv
tests/tcdm_mem_model.sv
tests/tb_tcdm_fifo.sv

// File: tests/tb_tcdm_fifo.sv
// TCDM queue testbench
`timescale 1ns/1ps
`default_nettype none

module tb_tcdm_fifo;

  import tcdm_fifo_pkg::*;

  localparam int     CLK_PERIOD   = 40;
  localparam int     RESET_CYCLES = 8;
  localparam int     SEED         = 15;
  localparam int     MEM_WORDS    = 16;
  localparam int     IDX_W        = $clog2(MEM_WORDS);
  localparam int     N_RANDOM     = 200;
  localparam int     BP_REQS      = 2 * FIFO_DEPTH;   // fills both queues
  localparam int     READY_LEN    = 1024;
  localparam addr_t  ADDR_BASE    = 32'h1000_0000;
  // cycle budget for reset, store/load, random, back-pressure and clear in turn
  localparam int     TEST_CYCLES  = RESET_CYCLES + 40 + 10 * N_RANDOM + 120 + 60;
  localparam int     MARGIN       = 4;
  localparam longint WATCHDOG_NS  = longint'(TEST_CYCLES) * CLK_PERIOD * MARGIN;

  logic     clk_i;
  logic     rst_ni;
  logic     clear_i;
  logic     tgt_req_i;
  addr_t    tgt_addr_i;
  data_t    tgt_wdata_i;
  be_t      tgt_be_i;
  tcdm_op_e tgt_op_i;
  logic     tgt_gnt_o;
  logic     tgt_r_valid_o;
  data_t    tgt_r_data_o;
  logic     tgt_r_ready_i;
  logic     init_req_o;
  addr_t    init_addr_o;
  data_t    init_wdata_o;
  be_t      init_be_o;
  tcdm_op_e init_op_o;
  logic     init_gnt_i;
  logic     init_r_valid_i;
  data_t    init_r_data_i;
  logic     init_r_ready_o;
  logic     empty_o;

  string     test_name;
  int        seed;
  logic      gnt_en;                 // memory grant enable
  bit        ready_rand;             // r_ready follows the random pattern
  int        pat_idx;
  data_t     last_rsp;
  data_t     ref_mem [MEM_WORDS];    // reference memory updated at acceptance
  data_t     exp_rsp [$];            // responses in request order
  req_word_t exp_req [$];            // requests the memory side should see
  bit        ready_pat [READY_LEN];
  tcdm_op_e  rnd_op    [N_RANDOM];
  addr_t     rnd_addr  [N_RANDOM];
  data_t     rnd_wdata [N_RANDOM];
  be_t       rnd_be    [N_RANDOM];

  tcdm_fifo i_tcdm_fifo (.*);

  tcdm_mem_model #(
    .WORDS ( MEM_WORDS ),
    .SEED  ( SEED      )
  ) i_mem (
    .clk_i     ( clk_i          ),
    .rst_ni    ( rst_ni         ),
    .gnt_en_i  ( gnt_en         ),
    .req_i     ( init_req_o     ),
    .addr_i    ( init_addr_o    ),
    .wdata_i   ( init_wdata_o   ),
    .be_i      ( init_be_o      ),
    .op_i      ( init_op_o      ),
    .gnt_o     ( init_gnt_i     ),
    .r_valid_o ( init_r_valid_i ),
    .r_data_o  ( init_r_data_i  )
  );

  always #(CLK_PERIOD / 2) clk_i = ~clk_i;

  function automatic data_t initial_word(int idx);
    return data_t'(32'h5EED_0000 + idx * 32'h0001_0203);
  endfunction

  function automatic data_t byte_mask(be_t be);
    data_t m;
    m = '0;
    for (int b = 0; b < BE_W; b++) begin
      if (be[b]) m[8*b +: 8] = 8'hFF;
    end
    return m;
  endfunction

  task automatic fail_run(string why);
    $display("%s", why);
    $display("TESTS FAILED");
    $fatal(1, "stopped at first failure");
  endtask

  task automatic check_data(string what, data_t exp, data_t act);
    if (act !== exp) begin
      fail_run($sformatf("error: %s %s expected %h actual %h",
                         test_name, what, exp, act));
    end
  endtask

  task automatic check_addr(string what, addr_t exp, addr_t act);
    if (act !== exp) begin
      fail_run($sformatf("error: %s %s expected %h actual %h",
                         test_name, what, exp, act));
    end
  endtask

  task automatic check_be(string what, be_t exp, be_t act);
    if (act !== exp) begin
      fail_run($sformatf("error: %s %s expected %b actual %b",
                         test_name, what, exp, act));
    end
  endtask

  task automatic check_op(string what, tcdm_op_e exp, tcdm_op_e act);
    if (act !== exp) begin
      fail_run($sformatf("error: %s %s expected %s actual %s",
                         test_name, what, exp.name(), act.name()));
    end
  endtask

  task automatic check_flag(string what, logic exp, logic act);
    if (act !== exp) begin
      fail_run($sformatf("error: %s %s expected %b actual %b",
                         test_name, what, exp, act));
    end
  endtask

  // scoreboard sampled on the rising edge before the DUT updates
  always @(posedge clk_i) begin : scoreboard
    req_word_t w;
    int        idx;
    if (rst_ni && !clear_i) begin
      if (init_req_o && init_gnt_i) begin   // memory side issue in acceptance order
        if (exp_req.size() == 0) fail_run("memory request issued with nothing accepted");
        w = exp_req.pop_front();
        check_addr("init_addr_o", w.addr, init_addr_o);
        check_data("init_wdata_o", w.wdata, init_wdata_o);
        check_be("init_be_o", w.be, init_be_o);
        check_op("init_op_o", w.op, init_op_o);
      end
      if (tgt_r_valid_o && tgt_r_ready_i) begin
        if (exp_rsp.size() == 0) fail_run("response returned with no request outstanding");
        last_rsp = tgt_r_data_o;
        check_data("tgt_r_data_o", exp_rsp.pop_front(), tgt_r_data_o);
      end
      if (tgt_req_i && tgt_gnt_o) begin     // predict the answer at acceptance
        w.addr  = tgt_addr_i;
        w.wdata = tgt_wdata_i;
        w.be    = tgt_be_i;
        w.op    = tgt_op_i;
        exp_req.push_back(w);
        idx = int'(tgt_addr_i[IDX_W+1:2]);
        if (tgt_op_i == OP_LOAD) begin
          exp_rsp.push_back(ref_mem[idx]);
        end else begin
          exp_rsp.push_back(data_t'(0));
          ref_mem[idx] = (ref_mem[idx] & ~byte_mask(tgt_be_i))
                       | (tgt_wdata_i & byte_mask(tgt_be_i));
        end
      end
    end
  end

  task automatic update_ready();
    if (ready_rand) begin
      tgt_r_ready_i = ready_pat[pat_idx % READY_LEN];
      pat_idx++;
    end
  endtask

  // starts on a falling edge and returns on the one after acceptance
  task automatic send_req(tcdm_op_e op, addr_t addr, data_t wdata, be_t be);
    update_ready();
    tgt_req_i   = 1'b1;
    tgt_op_i    = op;
    tgt_addr_i  = addr;
    tgt_wdata_i = wdata;
    tgt_be_i    = be;
    while (!tgt_gnt_o) begin          // gnt is registered and steady until the edge
      @(negedge clk_i);
      update_ready();
    end
    @(negedge clk_i);
    tgt_req_i = 1'b0;
  endtask

  task automatic wait_drained();
    while (exp_rsp.size() != 0) begin
      @(negedge clk_i);
      update_ready();
    end
  endtask

  task automatic check_idle_state();
    check_flag("empty_o", 1'b1, empty_o);
    check_flag("tgt_gnt_o", 1'b1, tgt_gnt_o);
    check_flag("init_req_o", 1'b0, init_req_o);
    check_flag("tgt_r_valid_o", 1'b0, tgt_r_valid_o);
    check_flag("init_r_ready_o", 1'b1, init_r_ready_o);
  endtask

  task automatic make_random_stimulus();
    for (int i = 0; i < N_RANDOM; i++) begin
      rnd_op[i]    = (($random(seed) & 1) != 0) ? OP_LOAD : OP_STORE;
      rnd_addr[i]  = ADDR_BASE + addr_t'(($random(seed) & (MEM_WORDS - 1)) * 4);
      rnd_wdata[i] = data_t'($random(seed));
      rnd_be[i]    = be_t'($random(seed));
    end
    for (int i = 0; i < READY_LEN; i++) begin
      ready_pat[i] = ($random(seed) & 3) != 0;   // ready about three cycles in four
    end
  endtask

  task automatic store_then_load();
    addr_t a;
    data_t merged;
    test_name = "store_load";
    a = ADDR_BASE + addr_t'(3 * 4);
    send_req(OP_STORE, a, 32'hCAFE_F00D, 4'b0101);
    send_req(OP_LOAD, a, '0, 4'hF);
    wait_drained();
    merged = (initial_word(3) & ~byte_mask(4'b0101)) | (32'hCAFE_F00D & byte_mask(4'b0101));
    check_data("load after store", merged, last_rsp);
  endtask

  task automatic random_traffic();
    test_name  = "random_traffic";
    ready_rand = 1'b1;
    for (int i = 0; i < N_RANDOM; i++) begin
      send_req(rnd_op[i], rnd_addr[i], rnd_wdata[i], rnd_be[i]);
    end
    wait_drained();
    ready_rand    = 1'b0;
    tgt_r_ready_i = 1'b1;
    check_flag("empty_o after drain", 1'b1, empty_o);
  endtask

  task automatic back_pressure();
    test_name     = "back_pressure";
    tgt_r_ready_i = 1'b0;             // core stops taking responses
    for (int i = 0; i < BP_REQS; i++) begin
      send_req((i % 2 == 1) ? OP_LOAD : OP_STORE, ADDR_BASE + addr_t'((i % MEM_WORDS) * 4),
               32'hB0B0_0000 + data_t'(i), 4'hF);
    end
    while (tgt_gnt_o) @(negedge clk_i);
    repeat (4) @(negedge clk_i);
    check_flag("tgt_gnt_o while full", 1'b0, tgt_gnt_o);
    check_flag("init_req_o while full", 1'b0, init_req_o);
    check_flag("init_r_ready_o while full", 1'b0, init_r_ready_o);
    check_flag("tgt_r_valid_o while full", 1'b1, tgt_r_valid_o);
    tgt_r_ready_i = 1'b1;
    wait_drained();
    check_flag("empty_o after drain", 1'b1, empty_o);
  endtask

  task automatic clear_flush();
    test_name = "clear";
    gnt_en    = 1'b0;                 // nothing left in flight at the memory
    repeat (2) @(negedge clk_i);
    for (int i = 0; i < 3; i++) begin
      send_req(OP_LOAD, ADDR_BASE + addr_t'(i * 4), '0, 4'hF);
    end
    check_flag("empty_o before clear", 1'b0, empty_o);
    clear_i = 1'b1;
    @(negedge clk_i);
    clear_i = 1'b0;
    check_idle_state();
    exp_req.delete();                 // flushed loads never reach the memory
    exp_rsp.delete();
    gnt_en = 1'b1;
    send_req(OP_LOAD, ADDR_BASE + addr_t'(5 * 4), '0, 4'hF);
    wait_drained();
  endtask

  initial begin
    #(WATCHDOG_NS);
    $display("watchdog expired during %s, the DUT stopped making progress", test_name);
    $display("TESTS FAILED");
    $fatal(1, "watchdog timeout");
  end

  initial begin
    clk_i         = 1'b0;
    rst_ni        = 1'b0;
    clear_i       = 1'b0;
    tgt_req_i     = 1'b0;
    tgt_addr_i    = '0;
    tgt_wdata_i   = '0;
    tgt_be_i      = '0;
    tgt_op_i      = OP_LOAD;
    tgt_r_ready_i = 1'b1;
    gnt_en        = 1'b1;
    ready_rand    = 1'b0;
    pat_idx       = 0;
    seed          = SEED;
    test_name     = "reset_state";
    for (int i = 0; i < MEM_WORDS; i++) ref_mem[i] = initial_word(i);
    make_random_stimulus();
    repeat (RESET_CYCLES) @(negedge clk_i);
    rst_ni = 1'b1;
    check_idle_state();
    store_then_load();
    random_traffic();
    back_pressure();
    clear_flush();
    if (exp_rsp.size() == 0 && exp_req.size() == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("%0d responses and %0d memory requests still outstanding",
               exp_rsp.size(), exp_req.size());
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule : tb_tcdm_fifo

`default_nettype wire

// File: tests/tcdm_mem_model.sv
// TCDM memory responder model
`timescale 1ns/1ps
`default_nettype none

module tcdm_mem_model #(
  parameter int WORDS = 16,   // word array size
  parameter int SEED  = 15
) (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  logic                    gnt_en_i,   // lets the testbench stall the memory
  input  logic                    req_i,
  input  tcdm_fifo_pkg::addr_t    addr_i,
  input  tcdm_fifo_pkg::data_t    wdata_i,
  input  tcdm_fifo_pkg::be_t      be_i,
  input  tcdm_fifo_pkg::tcdm_op_e op_i,
  output logic                    gnt_o,
  output logic                    r_valid_o,
  output tcdm_fifo_pkg::data_t    r_data_o
);

  import tcdm_fifo_pkg::*;

  localparam int IDX_W = $clog2(WORDS);

  data_t            mem_q [WORDS];
  int               seed;
  logic             gnt_rand;     // coin toss for this cycle
  logic             rsp_pend_q;   // granted last edge, answer this cycle
  data_t            rsp_data_q;
  logic [IDX_W-1:0] idx;

  assign idx   = addr_i[IDX_W+1:2];    // word index
  assign gnt_o = gnt_rand & gnt_en_i;

  initial begin
    seed      = SEED;
    gnt_rand  = 1'b0;
    r_valid_o = 1'b0;
    r_data_o  = '0;
    // start pattern, every word different
    for (int i = 0; i < WORDS; i++) begin
      mem_q[i] = data_t'(32'h5EED_0000 + i * 32'h0001_0203);
    end
  end

  // accept on req and gnt, read or byte-merged write
  always @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rsp_pend_q <= 1'b0;
    end else begin
      rsp_pend_q <= req_i & gnt_o;
      if (req_i & gnt_o) begin
        if (op_i == OP_LOAD) begin
          rsp_data_q <= mem_q[idx];
        end else begin
          rsp_data_q <= '0;            // stores answer with zero
          for (int b = 0; b < BE_W; b++) begin
            if (be_i[b]) mem_q[idx][8*b +: 8] = wdata_i[8*b +: 8];
          end
        end
      end
    end
  end

  // one-cycle response and a fresh random grant, on the falling edge
  always @(negedge clk_i) begin
    r_valid_o = rsp_pend_q;            // r_ready ignored, the DUT holds a miss
    r_data_o  = rsp_pend_q ? rsp_data_q : '0;
    gnt_rand  = ($random(seed) & 1) != 0;
  end

endmodule : tcdm_mem_model

`default_nettype wire
